/* src/ps2_params.svh */
`ifndef PS2_PARAMS_SVH
`define PS2_PARAMS_SVH

// scan-code buffer entries.
`define PS2_FIFO_DEPTH 8

// buffer pointer width, wide enough to index every entry.
`define PS2_PTR_W 3

// equal samples of the synchronized ps2_clk before a level is taken.
`define PS2_FILTER_LEN 4

`endif

/* src/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    // frame fields in arrival order, start bit lands in bit 0.
    typedef struct packed {
        logic       stop;
        logic       parity;
        logic [7:0] data;
        logic       start;
    } ps2_fields_t;

    // shifted in as raw bits, checked through the field view.
    typedef union packed {
        logic [10:0] raw;
        ps2_fields_t f;
    } ps2_frame_t;

    // scan-code set 2 prefixes.
    localparam logic [7:0] SC_BREAK  = 8'hF0;
    localparam logic [7:0] SC_EXTEND = 8'hE0;

endpackage

`default_nettype wire

/* src/display_pkg.sv */
`default_nettype none

package display_pkg;

    // active low, bit 7 is the decimal point.
    typedef logic [7:0] seg_t;

    localparam seg_t SEG_BLANK = 8'hFF;

    function automatic seg_t hex_to_seg(input logic [3:0] digit);
        seg_t pattern;
        case (digit)
            4'h0: pattern = 8'hC0;
            4'h1: pattern = 8'hF9;
            4'h2: pattern = 8'hA4;
            4'h3: pattern = 8'hB0;
            4'h4: pattern = 8'h99;
            4'h5: pattern = 8'h92;
            4'h6: pattern = 8'h82;
            4'h7: pattern = 8'hF8;
            4'h8: pattern = 8'h80;
            4'h9: pattern = 8'h90;
            4'hA: pattern = 8'h88;
            4'hB: pattern = 8'h83;
            4'hC: pattern = 8'hC6;
            4'hD: pattern = 8'hA1;
            4'hE: pattern = 8'h86;
            default: pattern = 8'h8E;
        endcase
        return pattern;
    endfunction

endpackage

`default_nettype wire

/* src/scan_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface scan_if;

    logic [7:0] data;
    logic       ready;
    logic       overflow;
    logic       nextdata_n;

    modport buffer (
        output data,
        output ready,
        output overflow,
        input  nextdata_n
    );

    // pop only while ready is high.
    modport reader (
        input  data,
        input  ready,
        input  overflow,
        output nextdata_n
    );

endinterface

`default_nettype wire

/* src/ps2_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ps2_params.svh"

module ps2_receiver (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] wr_data,
    output logic       wr_en
);
    import ps2_pkg::*;

    logic [1:0]                 clk_sync;
    logic [1:0]                 dat_sync;
    logic [`PS2_FILTER_LEN-1:0] clk_hist;
    logic                       clk_filt;
    logic                       fall;
    logic [3:0]                 bit_cnt;
    logic [9:0]                 idle_cnt;
    ps2_frame_t                 frame;
    ps2_frame_t                 frame_next;
    logic                       frame_ok;

    // both lines idle high.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_hist <= '1;
            clk_filt <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_hist <= {clk_hist[`PS2_FILTER_LEN-2:0], clk_sync[1]};
            if (clk_hist == '1)
                clk_filt <= 1'b1;
            else if (clk_hist == '0)
                clk_filt <= 1'b0;
        end
    end

    assign fall = clk_filt && (clk_hist == '0);

    // lsb first, so new bits enter at the top.
    always_comb
    begin
        frame_next.raw = {dat_sync[1], frame.raw[10:1]};
    end

    // odd parity over data and parity bit.
    assign frame_ok = (frame_next.f.start == 1'b0) &&
                      (frame_next.f.stop == 1'b1) &&
                      (^{frame_next.f.data, frame_next.f.parity} == 1'b1);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
            wr_en    <= 1'b0;
        end
        else
        begin
            wr_en <= 1'b0;
            if (fall)
            begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10)
                begin
                    bit_cnt <= '0;
                    wr_en   <= frame_ok;
                end
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
            else if (bit_cnt != '0 && clk_filt)
            begin
                // stuck mid-frame, start over.
                if (idle_cnt == 10'd1023)
                begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end
                else
                    idle_cnt <= idle_cnt + 10'd1;
            end
            else
                idle_cnt <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall)
            frame <= frame_next;
        if (fall && bit_cnt == 4'd10)
            wr_data <= frame_next.f.data;
    end

endmodule

`default_nettype wire

/* src/scan_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ps2_params.svh"

module scan_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] wr_data,
    input  logic       wr_en,
    scan_if.buffer     rd
);

    localparam logic [`PS2_PTR_W:0]   DEPTH    = (`PS2_PTR_W+1)'(`PS2_FIFO_DEPTH);
    localparam logic [`PS2_PTR_W-1:0] LAST_IDX = (`PS2_PTR_W)'(`PS2_FIFO_DEPTH - 1);

    logic [7:0]            mem [`PS2_FIFO_DEPTH];
    logic [`PS2_PTR_W-1:0] wr_ptr;
    logic [`PS2_PTR_W-1:0] rd_ptr;
    logic [`PS2_PTR_W:0]   count;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full     = (count == DEPTH);
    assign push     = wr_en && !full;
    assign pop      = !rd.nextdata_n && (count != '0);
    assign rd.ready = (count != '0);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            rd.overflow <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset.
            if (wr_en && full)
                rd.overflow <= 1'b1;
        end
    end

    // registered head byte.
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_data;
        rd.data <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

/* src/key_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
    input  logic              clk,
    input  logic              rst,
    input  logic              hold,
    scan_if.reader            rd,
    output display_pkg::seg_t seg1,
    output display_pkg::seg_t seg2,
    output display_pkg::seg_t seg3,
    output display_pkg::seg_t seg4
);
    import ps2_pkg::*;
    import display_pkg::*;

    localparam logic [2:0] IDLE         = 3'd0;
    localparam logic [2:0] FETCH        = 3'd1;
    localparam logic [2:0] POP          = 3'd2;
    localparam logic [2:0] AFTER_BREAK  = 3'd3;
    localparam logic [2:0] AFTER_EXTEND = 3'd4;

    logic [2:0] state;
    logic [2:0] wait_st;
    logic [7:0] key;
    logic [7:0] count;
    logic       blank;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state         <= IDLE;
            wait_st       <= IDLE;
            rd.nextdata_n <= 1'b1;
            key           <= '0;
            count         <= '0;
            blank         <= 1'b1;
        end
        else
        begin
            case (state)
                IDLE, AFTER_BREAK, AFTER_EXTEND:
                begin
                    // remember the prefix context for fetch.
                    if (rd.ready && !hold)
                    begin
                        wait_st <= state;
                        state   <= FETCH;
                    end
                end
                FETCH:
                begin
                    if (wait_st == AFTER_BREAK)
                    begin
                        blank   <= 1'b1;
                        wait_st <= IDLE;
                    end
                    else if (rd.data == SC_BREAK)
                        wait_st <= AFTER_BREAK;
                    else if (rd.data == SC_EXTEND)
                        wait_st <= AFTER_EXTEND;
                    else
                    begin
                        key     <= rd.data;
                        blank   <= 1'b0;
                        count   <= count + 8'd1;
                        wait_st <= IDLE;
                    end
                    rd.nextdata_n <= 1'b0;
                    state         <= POP;
                end
                POP:
                begin
                    rd.nextdata_n <= 1'b1;
                    state         <= wait_st;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst || blank)
        begin
            seg1 <= SEG_BLANK;
            seg2 <= SEG_BLANK;
            seg3 <= SEG_BLANK;
            seg4 <= SEG_BLANK;
        end
        else
        begin
            seg1 <= hex_to_seg(key[3:0]);
            seg2 <= hex_to_seg(key[7:4]);
            seg3 <= hex_to_seg(count[3:0]);
            seg4 <= hex_to_seg(count[7:4]);
        end
    end

endmodule

`default_nettype wire

/* src/ps2_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_display_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    input  logic       hold,
    output logic [7:0] seg1,
    output logic [7:0] seg2,
    output logic [7:0] seg3,
    output logic [7:0] seg4,
    output logic       overflow
);

    logic [7:0] rx_data;
    logic       rx_en;

    scan_if scan_bus ();

    ps2_receiver u_receiver (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .wr_data (rx_data),
        .wr_en   (rx_en)
    );

    scan_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (rx_data),
        .wr_en   (rx_en),
        .rd      (scan_bus)
    );

    key_decoder u_decoder (
        .clk  (clk),
        .rst  (rst),
        .hold (hold),
        .rd   (scan_bus),
        .seg1 (seg1),
        .seg2 (seg2),
        .seg3 (seg3),
        .seg4 (seg4)
    );

    assign overflow = scan_bus.overflow;

endmodule

`default_nettype wire

/* bench/tb_ps2_display.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ps2_params.svh"

module tb_ps2_display;
    import ps2_pkg::*;

    localparam int HALF_CLKS    = 40;
    localparam int FRAME_CLKS   = 11 * 2 * HALF_CLKS;
    localparam int RESET_CYCLES = 16;
    localparam int SETTLE       = 200;
    localparam int N_FRAMES     = 20 + 6 + 6 + 2 + `PS2_FIFO_DEPTH + 2;
    localparam int N_CHECKS     = N_FRAMES + 2;
    localparam int LIMIT        = 2 * (N_FRAMES * FRAME_CLKS + RESET_CYCLES
                                       + N_CHECKS * (SETTLE + 2));

    localparam logic [1:0] PFX_NONE   = 2'd0;
    localparam logic [1:0] PFX_BREAK  = 2'd1;
    localparam logic [1:0] PFX_EXTEND = 2'd2;

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_dat;
    logic       hold;
    logic [7:0] seg1;
    logic [7:0] seg2;
    logic [7:0] seg3;
    logic [7:0] seg4;
    logic       overflow;

    // reference model state.
    logic [7:0] m_key      = 8'h00;
    logic [7:0] m_count    = 8'h00;
    logic       m_blank    = 1'b1;
    logic [1:0] m_prefix   = PFX_NONE;
    logic [7:0] exp_seg [4] = '{8'hFF, 8'hFF, 8'hFF, 8'hFF};
    logic       exp_overflow = 1'b0;
    logic       holding      = 1'b0;
    logic [7:0] pending [$];

    logic [31:0] lfsr_state  = 32'd74712;
    logic        check_req   = 1'b0;
    int          err_count   = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    ps2_display_top dut (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .hold     (hold),
        .seg1     (seg1),
        .seg2     (seg2),
        .seg3     (seg3),
        .seg4     (seg4),
        .overflow (overflow)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        else
            return s >> 1;
    endfunction

    // prefix bytes are redrawn.
    function automatic logic [7:0] random_code();
        logic [7:0] code;
        int         b;
        code = SC_BREAK;
        while (code == SC_BREAK || code == SC_EXTEND)
        begin
            for (b = 0; b < 8; b++)
            begin
                lfsr_state = lfsr_next(lfsr_state);
                code[b] = lfsr_state[0];
            end
        end
        return code;
    endfunction

    function automatic logic [7:0] seg_pattern(input logic [3:0] digit);
        case (digit)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    // one byte through the make/break/extend rules.
    function automatic void model_byte(input logic [7:0] code);
        if (m_prefix == PFX_BREAK)
        begin
            m_blank  = 1'b1;
            m_prefix = PFX_NONE;
        end
        else if (code == SC_BREAK)
            m_prefix = PFX_BREAK;
        else if (code == SC_EXTEND)
            m_prefix = PFX_EXTEND;
        else
        begin
            m_key    = code;
            m_blank  = 1'b0;
            m_count  = m_count + 8'd1;
            m_prefix = PFX_NONE;
        end
        if (m_blank)
            exp_seg = '{8'hFF, 8'hFF, 8'hFF, 8'hFF};
        else
            exp_seg = '{seg_pattern(m_key[3:0]), seg_pattern(m_key[7:4]),
                        seg_pattern(m_count[3:0]), seg_pattern(m_count[7:4])};
    endfunction

    // data changes mid-high, lsb first after the start bit.
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        ps2_frame_t frame;
        int         i;
        frame.f.start  = 1'b0;
        frame.f.data   = code;
        frame.f.parity = ~(^code) ^ bad_parity;
        frame.f.stop   = 1'b1;
        for (i = 0; i < 11; i++)
        begin
            ps2_dat <= frame.raw[i];
            repeat (HALF_CLKS / 2) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (HALF_CLKS) @(posedge clk);
            ps2_clk <= 1'b1;
            repeat (HALF_CLKS / 2) @(posedge clk);
        end
        ps2_dat <= 1'b1;
    endtask

    task automatic settle_and_check();
        repeat (SETTLE) @(posedge clk);
        check_req <= 1'b1;
        @(posedge clk);
        check_req <= 1'b0;
        @(posedge clk);
    endtask

    // held bytes wait in the buffer model until it is full.
    task automatic send_code(input logic [7:0] code);
        send_frame(code, 1'b0);
        if (holding)
        begin
            if (pending.size() < `PS2_FIFO_DEPTH)
                pending.push_back(code);
            else
                exp_overflow = 1'b1;
        end
        else
            model_byte(code);
        settle_and_check();
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            tests_passed = tests_passed + 1;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d mismatches", name, err_count - errs_before);
        end
    endtask

    always @(posedge clk)
    begin
        logic [7:0] seen [4];
        int         k;
        seen = '{seg1, seg2, seg3, seg4};
        if (check_req)
        begin
            check_count = check_count + 1;
            for (k = 0; k < 4; k++)
            begin
                if (seen[k] !== exp_seg[k])
                begin
                    $display("ERR %0t: seg%0d expected %h, seen %h",
                             $time, k + 1, exp_seg[k], seen[k]);
                    err_count = err_count + 1;
                end
            end
            if (overflow !== exp_overflow)
            begin
                $display("ERR %0t: overflow expected %b, seen %b",
                         $time, exp_overflow, overflow);
                err_count = err_count + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial
    begin
        int         errs;
        int         i;
        logic [7:0] code;
        rst     = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        hold    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;

        errs = err_count;
        settle_and_check();
        end_test("reset", errs);

        errs = err_count;
        for (i = 0; i < 20; i++)
            send_code(random_code());
        end_test("make codes", errs);

        errs = err_count;
        for (i = 0; i < 2; i++)
        begin
            send_code(SC_BREAK);
            send_code(random_code());
            send_code(random_code());
        end
        end_test("break sequence", errs);

        errs = err_count;
        send_code(SC_EXTEND);
        send_code(random_code());
        send_code(SC_EXTEND);
        send_code(SC_BREAK);
        send_code(random_code());
        send_code(random_code());
        end_test("extended prefix", errs);

        // a bad frame is dropped before the buffer.
        errs = err_count;
        send_frame(random_code(), 1'b1);
        settle_and_check();
        send_code(random_code());
        end_test("parity error", errs);

        errs = err_count;
        hold   <= 1'b1;
        holding = 1'b1;
        @(posedge clk);
        for (i = 0; i < `PS2_FIFO_DEPTH + 2; i++)
            send_code(random_code());
        hold   <= 1'b0;
        holding = 1'b0;
        while (pending.size() > 0)
        begin
            code = pending.pop_front();
            model_byte(code);
        end
        settle_and_check();
        end_test("hold and overflow", errs);

        $display("tests passed: %0d, failed: %0d, checks: %0d, mismatches: %0d",
                 tests_passed, tests_failed, check_count, err_count);
        if (tests_failed == 0 && err_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
src/ps2_pkg.sv
src/display_pkg.sv
src/scan_if.sv
src/ps2_receiver.sv
src/scan_fifo.sv
src/key_decoder.sv
src/ps2_display_top.sv
bench/tb_ps2_display.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module tb_ps2_display -o tb_ps2_display \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_ps2_display > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "no result in log"; exit 1; }
exit 0
